// ==== src.f ====
source/train_cfg_pkg.sv
source/train_ctrl_pkg.sv
source/sample_addr_gen.sv
source/training_counters.sv
source/training_sequencer.sv
source/nn_train_ctrl.sv
bench/nn_train_ctrl_checks.sv
bench/nn_train_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: nn_train_ctrl

sources:
  - source/train_cfg_pkg.sv
  - source/train_ctrl_pkg.sv
  - source/sample_addr_gen.sv
  - source/training_counters.sv
  - source/training_sequencer.sv
  - source/nn_train_ctrl.sv
  - target: simulation
    files:
      - bench/nn_train_ctrl_checks.sv
      - bench/nn_train_ctrl_tb.sv

// ==== bench/nn_train_ctrl_tb.sv ====
`timescale 1ns/1ps
//**************************************************
// training controller testbench, drives enable and
// keeps reference counts for the end of run
//**************************************************
module nn_train_ctrl_tb
    import train_cfg_pkg::*;
    import train_ctrl_pkg::*;
();
    localparam int    SAMPLE_COUNT = 6;
    localparam int    EPOCHS       = 2;
    localparam int    TIMEOUT      = 2000;
    localparam addr_t LAST         = addr_t'(SAMPLE_COUNT - 1);

    logic clk, reset, enable;
    logic reset_local, block_reset_on_mux, en_forward, en_backward, load_initial_parameters;
    sweep_src_e input_select;
    addr_t      address;
    cycle_t     train_cycles;
    logic       check_failed;
    int         seed = 66383;
    int         rnd;
    int         stored_sweeps, feedback_sweeps;
    longint     fwd_cycles;
    addr_t      last_seen;

    nn_train_ctrl #(.SAMPLE_COUNT(SAMPLE_COUNT), .PACE(2), .SETTLE(5), .LOAD(4),
                    .EPOCHS(EPOCHS)) u_nn_train_ctrl (.*);

    nn_train_ctrl_checks #(.SAMPLE_COUNT(SAMPLE_COUNT), .PACE(2), .SETTLE(5), .LOAD(4))
        u_checks (.*, .failed(check_failed));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reference counts over enabled cycles
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            stored_sweeps   <= 0;
            feedback_sweeps <= 0;
            fwd_cycles      <= 0;
            last_seen       <= '0;
        end else if (enable) begin
            if (en_forward)
                fwd_cycles <= fwd_cycles + 1;
            // a sweep reaching its last sample
            if (address == LAST && last_seen != LAST) begin
                if (input_select == src_feedback)
                    feedback_sweeps <= feedback_sweeps + 1;
                else
                    stored_sweeps <= stored_sweeps + 1;
            end
            last_seen <= address;
        end
    end

    always @(posedge check_failed) begin
        $display("CHECKS FAILED");
        $fatal(1, "assertion failure in the port checks");
    end

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic compare_value(input string name, input longint exp, input longint act);
        assert (exp == act) else begin
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "end of run mismatch");
        end
    endtask

    initial begin
        int cycles;
        reset  = 1'b1;
        enable = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset  = 1'b0;
        enable = 1'b1;
        cycles = 0;
        while (input_select != src_feedback) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                give_up("the first refinement sweep");
        end
        // pause stretch inside the refinement sweeps
        repeat (60) begin
            @(negedge clk);
            rnd    = $random(seed);
            enable = rnd[0];
        end
        @(negedge clk);
        enable = 1'b1;
        cycles = 0;
        while (!(input_select == src_feedback && !block_reset_on_mux && address == '0)) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                give_up("the done state");
        end
        // let the done checks watch for a while
        repeat (20) @(negedge clk);
        compare_value("stored sweeps", 2, stored_sweeps);
        compare_value("feedback sweeps", EPOCHS, feedback_sweeps);
        compare_value("train cycles", fwd_cycles, train_cycles);
        compare_value("done en_forward", 0, en_forward);
        compare_value("done en_backward", 0, en_backward);
        compare_value("done reset_local", 1, reset_local);
        compare_value("done address", 0, address);
        if (check_failed) begin
            $display("CHECKS FAILED");
            $fatal(1, "assertion failure in the port checks");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== bench/nn_train_ctrl_checks.sv ====
`timescale 1ns/1ps
//**************************************************
// port checks for the training controller
//**************************************************
module nn_train_ctrl_checks
    import train_cfg_pkg::*;
    import train_ctrl_pkg::*;
#(
    parameter int SAMPLE_COUNT = 6,
    parameter int PACE         = 2,
    parameter int SETTLE       = 5,
    parameter int LOAD         = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic       reset_local,
    input  logic       block_reset_on_mux,
    input  logic       en_forward,
    input  logic       en_backward,
    input  logic       load_initial_parameters,
    input  sweep_src_e input_select,
    input  addr_t      address,
    input  cycle_t     train_cycles,
    output logic       failed
);
    localparam addr_t LAST = addr_t'(SAMPLE_COUNT - 1);

    // address of the previous enabled cycle and how long it ran
    addr_t  prev_addr;
    int     run_len;
    int     drain_run;
    logic   load_prev;
    int     load_run;
    logic   rl_prev;
    int     rl_run;
    logic   quiet;
    logic   at_done;
    logic   addr_change;
    logic [101:0] outs;

    assign quiet   = !reset_local && !block_reset_on_mux && !en_forward && !en_backward
                     && !load_initial_parameters && (input_select == src_stored)
                     && (address == '0) && (train_cycles == '0);
    assign at_done = !block_reset_on_mux && (input_select == src_feedback) && (address == '0);
    assign addr_change = enable && (address != prev_addr);
    assign outs = {reset_local, block_reset_on_mux, en_forward, en_backward,
                   load_initial_parameters, input_select, address, train_cycles};

    initial failed = 1'b0;

    task automatic flag_mismatch(input string name, input longint exp, input longint act);
        $display("FAILED %s expected %0d actual %0d", name, exp, act);
        failed = 1'b1;
    endtask

    task automatic flag_failure(input string what);
        $display("%s", what);
        failed = 1'b1;
    endtask

    // run lengths over enabled cycles only
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_addr <= '0;
            run_len   <= 0;
            drain_run <= 0;
            load_prev <= 1'b0;
            load_run  <= 0;
            rl_prev   <= 1'b0;
            rl_run    <= 0;
        end else if (enable) begin
            if (address != prev_addr) begin
                prev_addr <= address;
                // turn and epoch reset cycles belong to no sweep address
                run_len   <= (address == '0) ? 0 : 1;
            end else if (en_forward) begin
                run_len <= run_len + 1;
            end
            drain_run <= (address == LAST && !en_forward) ? drain_run + 1 : 0;
            load_prev <= load_initial_parameters;
            load_run  <= load_initial_parameters ? load_run + 1 : 0;
            rl_prev   <= reset_local;
            rl_run    <= !reset_local ? rl_run + 1 : 0;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) reset |-> quiet)
        else flag_failure("outputs not quiet during reset");
    a_after_reset: assert property (@(posedge clk) $fell(reset) |-> quiet)
        else flag_failure("outputs not quiet right after reset");
    a_addr_step: assert property (@(posedge clk) disable iff (reset)
        addr_change && address != '0 |-> address == prev_addr + 1)
        else flag_mismatch("address step", prev_addr + 1, address);
    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        addr_change && address != '0 |-> run_len == PACE + 1)
        else flag_mismatch("address hold", PACE + 1, run_len);
    a_sweep_end: assert property (@(posedge clk) disable iff (reset)
        addr_change && address == '0 |-> prev_addr == LAST)
        else flag_mismatch("sweep end address", LAST, prev_addr);
    a_turn: assert property (@(posedge clk) disable iff (reset)
        addr_change && address == '0 && reset_local && block_reset_on_mux |-> run_len == 1)
        else flag_mismatch("warm turn last address", 1, run_len);
    // one last-sample cycle of the sweep plus the settle window
    a_settle_window: assert property (@(posedge clk) disable iff (reset)
        addr_change && address == '0 && !reset_local
        |-> run_len == SETTLE + 2)
        else flag_mismatch("settle window", SETTLE + 2, run_len);
    a_drain_window: assert property (@(posedge clk) disable iff (reset)
        addr_change && address == '0 && !block_reset_on_mux |-> drain_run == SETTLE + 1)
        else flag_mismatch("drain window", SETTLE + 1, drain_run);
    a_addr_range: assert property (@(posedge clk) disable iff (reset) address <= LAST)
        else flag_mismatch("address range", LAST, address);
    a_load_len: assert property (@(posedge clk) disable iff (reset)
        enable && load_prev && !load_initial_parameters |-> load_run == LOAD + 1)
        else flag_mismatch("load length", LOAD + 1, load_run);
    a_load_levels: assert property (@(posedge clk) disable iff (reset)
        load_initial_parameters |-> reset_local && block_reset_on_mux && !en_forward)
        else flag_failure("wrong control levels during parameter load");
    a_epoch_reset: assert property (@(posedge clk) disable iff (reset)
        enable && reset_local && !rl_prev && input_select == src_feedback |-> rl_run == 1)
        else flag_mismatch("epoch local reset", 1, rl_run);
    a_freeze: assert property (@(posedge clk) disable iff (reset) !enable |=> $stable(outs))
        else flag_failure("outputs changed while enable was low");
    a_done_stable: assert property (@(posedge clk) disable iff (reset)
        at_done |=> $stable(outs) && at_done)
        else flag_failure("outputs moved after reaching done");

endmodule

// ==== source/nn_train_ctrl.sv ====
`timescale 1ns/1ps
//**************************************************
// training-run controller top, phase FSM with its
// address generator and delay counters
//**************************************************
module nn_train_ctrl
    import train_cfg_pkg::*;
    import train_ctrl_pkg::*;
#(
    parameter int SAMPLE_COUNT = DEF_SAMPLE_COUNT,
    parameter int PACE         = DEF_PACE,
    parameter int SETTLE       = DEF_SETTLE,
    parameter int LOAD         = DEF_LOAD,
    parameter int EPOCHS       = DEF_EPOCHS
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    output logic       reset_local,
    output logic       block_reset_on_mux,
    output logic       en_forward,
    output logic       en_backward,
    output logic       load_initial_parameters,
    output sweep_src_e input_select,
    output addr_t      address,
    output cycle_t     train_cycles
);
    // sequencer requests
    logic en_address;
    logic en_settle;
    logic en_epoch;
    // flags back from the counters
    logic sweep_last;
    logic load_done;
    logic settle_done;
    logic last_epoch;

    training_sequencer u_training_sequencer (
        .clk                     (clk),
        .reset                   (reset),
        .enable                  (enable),
        .sweep_last              (sweep_last),
        .load_done               (load_done),
        .settle_done             (settle_done),
        .last_epoch              (last_epoch),
        .reset_local             (reset_local),
        .block_reset_on_mux      (block_reset_on_mux),
        .en_forward              (en_forward),
        .en_backward             (en_backward),
        .load_initial_parameters (load_initial_parameters),
        .en_address              (en_address),
        .en_settle               (en_settle),
        .en_epoch                (en_epoch),
        .input_select            (input_select)
    );

    sample_addr_gen #(
        .SAMPLE_COUNT (SAMPLE_COUNT),
        .PACE         (PACE)
    ) u_sample_addr_gen (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .en_address (en_address),
        .en_settle  (en_settle),
        .address    (address),
        .sweep_last (sweep_last)
    );

    training_counters #(
        .SETTLE (SETTLE),
        .LOAD   (LOAD),
        .EPOCHS (EPOCHS)
    ) u_training_counters (
        .clk                     (clk),
        .reset                   (reset),
        .enable                  (enable),
        .load_initial_parameters (load_initial_parameters),
        .en_settle               (en_settle),
        .en_epoch                (en_epoch),
        .en_forward              (en_forward),
        .load_done               (load_done),
        .settle_done             (settle_done),
        .last_epoch              (last_epoch),
        .train_cycles            (train_cycles)
    );

endmodule

// ==== source/training_sequencer.sv ====
`timescale 1ns/1ps
//**************************************************
// training phase FSM, steps through load, warm-up,
// refinement and drain and decodes the control levels
//**************************************************
module training_sequencer
    import train_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic       sweep_last,
    input  logic       load_done,
    input  logic       settle_done,
    input  logic       last_epoch,
    output logic       reset_local,
    output logic       block_reset_on_mux,
    output logic       en_forward,
    output logic       en_backward,
    output logic       load_initial_parameters,
    output logic       en_address,
    output logic       en_settle,
    output logic       en_epoch,
    output sweep_src_e input_select
);
    train_state_e state_q;
    train_state_e state_d;

    // state register, frozen while enable is low
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state_q <= idle;
        else if (enable)
            state_q <= state_d;
    end

    // phase order
    // load_done the port shadows load_done the state, so the state is scoped
    always_comb begin
        state_d = state_q;
        case (state_q)
            idle:         state_d = hold_reset;
            hold_reset:   state_d = load;
            load: begin
                if (load_done)
                    state_d = train_ctrl_pkg::load_done;
            end
            train_ctrl_pkg::load_done:
                state_d = warm1_start;
            warm1_start:  state_d = warm1_sweep;
            warm1_sweep: begin
                if (sweep_last)
                    state_d = warm_turn;
            end
            warm_turn:    state_d = warm2_start;
            warm2_start:  state_d = warm2_sweep;
            warm2_sweep: begin
                if (sweep_last)
                    state_d = warm_gap;
            end
            warm_gap:     state_d = warm_settle;
            warm_settle: begin
                if (settle_done)
                    state_d = epoch_reset;
            end
            epoch_reset:  state_d = epoch_start;
            epoch_start:  state_d = epoch_sweep;
            epoch_sweep: begin
                if (sweep_last)
                    state_d = epoch_gap;
            end
            epoch_gap:    state_d = epoch_settle;
            epoch_settle: begin
                // another refinement sweep unless the last one just ran
                if (settle_done)
                    state_d = last_epoch ? drain_gap : epoch_reset;
            end
            drain_gap:    state_d = drain_settle;
            drain_settle: begin
                if (settle_done)
                    state_d = done;
            end
            done:         state_d = done;
            default:      state_d = idle;
        endcase
    end

    // control levels per state
    always_comb begin
        reset_local             = 1'b1;
        block_reset_on_mux      = 1'b1;
        en_forward              = 1'b0;
        en_backward             = 1'b0;
        load_initial_parameters = 1'b0;
        en_address              = 1'b0;
        en_settle               = 1'b0;
        en_epoch                = 1'b0;
        input_select            = src_stored;
        case (state_q)
            idle: begin
                // everything quiet until the first enabled cycle
                reset_local        = 1'b0;
                block_reset_on_mux = 1'b0;
            end
            load:
                load_initial_parameters = 1'b1;
            warm1_start, warm1_sweep, warm2_start, warm2_sweep: begin
                en_forward  = 1'b1;
                en_backward = 1'b1;
                en_address  = 1'b1;
            end
            warm_turn: begin
                // address back to 0 for the second warm-up sweep
                en_forward  = 1'b1;
                en_backward = 1'b1;
            end
            warm_gap, warm_settle: begin
                en_forward  = 1'b1;
                en_backward = 1'b1;
                en_settle   = 1'b1;
            end
            epoch_reset: begin
                // one cycle of local reset before each refinement sweep
                reset_local  = 1'b0;
                en_forward   = 1'b1;
                en_backward  = 1'b1;
                en_epoch     = 1'b1;
                input_select = src_feedback;
            end
            epoch_start, epoch_sweep: begin
                en_forward   = 1'b1;
                en_backward  = 1'b1;
                en_address   = 1'b1;
                input_select = src_feedback;
            end
            epoch_gap, epoch_settle: begin
                en_forward   = 1'b1;
                en_backward  = 1'b1;
                en_settle    = 1'b1;
                input_select = src_feedback;
            end
            drain_gap, drain_settle: begin
                block_reset_on_mux = 1'b0;
                en_settle          = 1'b1;
                input_select       = src_feedback;
            end
            done: begin
                block_reset_on_mux = 1'b0;
                input_select       = src_feedback;
            end
            default: begin
                // hold_reset and load_done only keep the datapath in reset
            end
        endcase
    end

    // parameter load never overlaps a sweep on the sample memory
    a_load_vs_sweep: assert property (@(posedge clk) disable iff (reset)
        !(en_address && load_initial_parameters))
        else $error("sample sweep during parameter load");

endmodule

// ==== source/training_counters.sv ====
`timescale 1ns/1ps
//**************************************************
// load, settle and epoch delay counters plus the
// running count of training cycles
//**************************************************
module training_counters
    import train_cfg_pkg::*;
#(
    parameter int SETTLE = DEF_SETTLE,
    parameter int LOAD   = DEF_LOAD,
    parameter int EPOCHS = DEF_EPOCHS
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   enable,
    input  logic   load_initial_parameters,
    input  logic   en_settle,
    input  logic   en_epoch,
    input  logic   en_forward,
    output logic   load_done,
    output logic   settle_done,
    output logic   last_epoch,
    output cycle_t train_cycles
);
    localparam int LOAD_W   = $clog2(LOAD + 2);
    localparam int SETTLE_W = $clog2(SETTLE + 2);
    localparam int EPOCH_W  = $clog2(EPOCHS + 2);

    logic [LOAD_W-1:0]   load_cnt;
    logic [SETTLE_W-1:0] settle_cnt;
    logic [EPOCH_W-1:0]  epoch_cnt;

    // terminal counts, only meaningful while the phase is active
    assign load_done   = load_initial_parameters && (load_cnt == LOAD_W'(LOAD));
    assign settle_done = en_settle && (settle_cnt == SETTLE_W'(SETTLE));
    assign last_epoch  = (epoch_cnt == EPOCH_W'(EPOCHS));

    // load window, wraps to 0 on its terminal count
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            load_cnt <= '0;
        else if (enable) begin
            if (!load_initial_parameters || load_done)
                load_cnt <= '0;
            else
                load_cnt <= load_cnt + 1'b1;
        end
    end

    // settle window, wrap matters when one window follows another directly
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            settle_cnt <= '0;
        else if (enable) begin
            if (!en_settle || settle_done)
                settle_cnt <= '0;
            else
                settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // refinement sweeps started, saturates at EPOCHS
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            epoch_cnt <= '0;
        else if (enable && en_epoch && !last_epoch)
            epoch_cnt <= epoch_cnt + 1'b1;
    end

    // cycles with the forward path running
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            train_cycles <= '0;
        else if (enable && en_forward)
            train_cycles <= train_cycles + 1'b1;
    end

    a_settle_bound: assert property (@(posedge clk) disable iff (reset)
        settle_cnt <= SETTLE_W'(SETTLE))
        else $error("settle count %0d past terminal count", settle_cnt);

endmodule

// ==== source/sample_addr_gen.sv ====
`timescale 1ns/1ps
//**************************************************
// paced sample address generator, holds each address
// PACE+1 cycles and flags the last sample of a sweep
//**************************************************
module sample_addr_gen
    import train_cfg_pkg::*;
#(
    parameter int SAMPLE_COUNT = DEF_SAMPLE_COUNT,
    parameter int PACE         = DEF_PACE
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  enable,
    input  logic  en_address,
    input  logic  en_settle,
    output addr_t address,
    output logic  sweep_last
);
    localparam int    PACE_W    = $clog2(PACE + 2);
    localparam addr_t LAST_ADDR = addr_t'(SAMPLE_COUNT - 1);

    logic [PACE_W-1:0] pace_cnt;
    logic              pace_wrap;
    addr_t             addr_q;

    // last cycle of the current address
    assign pace_wrap  = (pace_cnt == PACE_W'(PACE));
    // the sweep ends on the edge after this
    assign sweep_last = en_address && (addr_q == LAST_ADDR);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pace_cnt <= '0;
            addr_q   <= '0;
        end else if (enable) begin
            if (!en_address) begin
                // outside a sweep, next sweep starts at sample 0
                pace_cnt <= '0;
                addr_q   <= '0;
            end else if (pace_wrap) begin
                pace_cnt <= '0;
                // stop at the last sample
                if (!sweep_last) begin
                    addr_q <= addr_q + 1'b1;
                end
            end else begin
                pace_cnt <= pace_cnt + 1'b1;
            end
        end
    end

    // last sample parked during settle, sample 0 otherwise
    always_comb begin
        if (en_address)
            address = addr_q;
        else if (en_settle)
            address = LAST_ADDR;
        else
            address = '0;
    end

    a_addr_in_range: assert property (@(posedge clk) disable iff (reset)
        address <= LAST_ADDR)
        else $error("sample address %0d past last sample", address);

endmodule

// ==== source/train_ctrl_pkg.sv ====
//**************************************************
// training sequencer state and sweep source encodings
//**************************************************
package train_ctrl_pkg;

    // phase order of one training run
    typedef enum logic [4:0] {
        idle,
        hold_reset,
        load,
        load_done,
        // two warm-up sweeps on stored samples
        warm1_start,
        warm1_sweep,
        warm_turn,
        warm2_start,
        warm2_sweep,
        warm_gap,
        warm_settle,
        // refinement sweeps on fed-back samples
        epoch_reset,
        epoch_start,
        epoch_sweep,
        epoch_gap,
        epoch_settle,
        // wind down, then rest
        drain_gap,
        drain_settle,
        done
    } train_state_e;

    // datapath input mux source
    typedef enum logic {
        src_stored   = 1'b0,
        src_feedback = 1'b1
    } sweep_src_e;

endpackage

// ==== source/train_cfg_pkg.sv ====
//**************************************************
// training controller sizing defaults and the
// sample address and cycle count types
//**************************************************
package train_cfg_pkg;

    // samples in the sample memory, one sweep visits each once
    localparam int DEF_SAMPLE_COUNT = 2048;

    // extra cycles each address is held
    localparam int DEF_PACE = 100;

    // terminal count of the settle delay between sweeps
    localparam int DEF_SETTLE = 2000;

    // terminal count of the initial parameter load
    localparam int DEF_LOAD = 4;

    // refinement sweeps on fed-back samples
    localparam int DEF_EPOCHS = 1;

    localparam int ADDR_W  = 32;
    localparam int CYCLE_W = 64;

    // sample memory address
    typedef logic [ADDR_W-1:0] addr_t;

    // running count of training cycles
    typedef logic [CYCLE_W-1:0] cycle_t;

endpackage
